// File: logic/cdot_pkg.sv
package cdot_pkg;

  // one real or imaginary component
  parameter int CPLX_W = 16;

  // sum of two full 32-bit partial products
  parameter int PROD_W = 2*CPLX_W + 1;

  // reduced result, headroom for any lane count in use
  parameter int ACC_W = 40;

  // re in the upper half of the word
  typedef struct packed {
    logic signed [CPLX_W-1:0] re;
    logic signed [CPLX_W-1:0] im;
  } cplx_t;

  // same operand word, raw at the ports, split in the datapath
  typedef union packed {
    logic [2*CPLX_W-1:0] raw;
    cplx_t               cplx;
  } cplx_word_u;

  // final dot product
  typedef struct packed {
    logic signed [ACC_W-1:0] re;
    logic signed [ACC_W-1:0] im;
  } acc_t;

endpackage

// File: logic/cplx_stream_if.sv
interface cplx_stream_if #(
  parameter int LANES = 8
);
  import cdot_pkg::*;

  // beat of lane products leaving the multiplier stage
  logic                     valid;
  logic                     ready;
  logic signed [PROD_W-1:0] prod_re [LANES];
  logic signed [PROD_W-1:0] prod_im [LANES];

  // multiplier side
  modport producer (
    output valid,
    output prod_re,
    output prod_im,
    input  ready
  );

  // adder tree side, owns the stall decision
  modport consumer (
    input  valid,
    input  prod_re,
    input  prod_im,
    output ready
  );

endinterface

// File: logic/complex_mul.sv
module complex_mul (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               en_i,
  input  cdot_pkg::cplx_word_u               a_i,
  input  cdot_pkg::cplx_word_u               b_i,
  input  logic                               conj_i,
  output logic signed [cdot_pkg::PROD_W-1:0] prod_re_o,
  output logic signed [cdot_pkg::PROD_W-1:0] prod_im_o
);
  import cdot_pkg::*;

  // partial product width
  localparam int PP_W = 2*CPLX_W;

  // b imaginary part, one extra bit so -(-32768) fits
  logic signed [CPLX_W:0] b_im_ext;
  logic signed [CPLX_W:0] b_im_eff;

  // stage 1 partial products
  logic signed [PP_W-1:0] rr_q;
  logic signed [PP_W-1:0] ii_q;
  logic signed [PP_W-1:0] ri_q;
  logic signed [PP_W-1:0] ir_q;

  // sign extend, then optionally negate
  assign b_im_ext = b_i.cplx.im;
  assign b_im_eff = conj_i ? -b_im_ext : b_im_ext;

  // stage 1
  // magnitudes stay within 2^30, so 32 bits hold every product
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_q <= '0;
      ii_q <= '0;
      ri_q <= '0;
      ir_q <= '0;
    end else if (en_i) begin
      rr_q <= a_i.cplx.re * b_i.cplx.re;
      ii_q <= a_i.cplx.im * b_im_eff;
      ri_q <= a_i.cplx.re * b_im_eff;
      ir_q <= a_i.cplx.im * b_i.cplx.re;
    end
  end

  // stage 2
  // re = ar*br - ai*bi, im = ar*bi + ai*br
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      prod_re_o <= '0;
      prod_im_o <= '0;
    end else if (en_i) begin
      prod_re_o <= rr_q - ii_q;
      prod_im_o <= ri_q + ir_q;
    end
  end

endmodule

// File: logic/complex_add_tree.sv
module complex_add_tree #(
  parameter int LANES = 8
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   flush_i,
  input  logic                   out_ready_i,
  cplx_stream_if.consumer        in,
  output cdot_pkg::acc_t         result_o,
  output logic                   out_valid_o,
  output logic                   busy_o
);
  import cdot_pkg::*;

  localparam int LOG_LANES = $clog2(LANES);
  localparam int NODES     = 2*LANES - 1;

  // heap order, node n sums nodes 2n+1 and 2n+2
  // nodes 0 .. LANES-2 are registers, the rest are the lane inputs
  logic signed [ACC_W-1:0] node_re [NODES];
  logic signed [ACC_W-1:0] node_im [NODES];

  // one valid bit per tree level, index 0 nearest the inputs
  logic [LOG_LANES-1:0] lvl_v_q;

  // global stall
  logic advance;

  // last stage empty or being drained
  assign advance  = !lvl_v_q[LOG_LANES-1] || out_ready_i;
  assign in.ready = advance;

  // leaves
  // sign extension up to the result width
  for (genvar l = 0; l < LANES; l++) begin : g_leaf
    assign node_re[LANES-1+l] = in.prod_re[l];
    assign node_im[LANES-1+l] = in.prod_im[l];
  end

  // internal adders
  // all nodes of one depth register on the same edge
  for (genvar n = 0; n < LANES-1; n++) begin : g_node
    always_ff @(posedge clk_i) begin
      if (advance) begin
        node_re[n] <= node_re[2*n+1] + node_re[2*n+2];
        node_im[n] <= node_im[2*n+1] + node_im[2*n+2];
      end
    end
  end

  // valid shift register, moves in step with the data
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      lvl_v_q <= '0;
    end else if (advance) begin
      lvl_v_q[0] <= in.valid;
      for (int k = 1; k < LOG_LANES; k++) begin
        lvl_v_q[k] <= lvl_v_q[k-1];
      end
    end
  end

  // root of the tree is the result
  assign result_o.re = node_re[0];
  assign result_o.im = node_im[0];
  assign out_valid_o = lvl_v_q[LOG_LANES-1];

  // anything still inside the tree
  assign busy_o = |lvl_v_q;

endmodule

// File: logic/complex_dot_product.sv
module complex_dot_product #(
  parameter int LANES = 8
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  cdot_pkg::cplx_word_u [LANES-1:0] a_i,
  input  cdot_pkg::cplx_word_u [LANES-1:0] b_i,
  input  logic                             conj_i,
  input  logic                             in_valid_i,
  output logic                             in_ready_o,
  input  logic                             flush_i,
  output cdot_pkg::acc_t                   result_o,
  output logic                             out_valid_o,
  input  logic                             out_ready_i,
  output logic                             busy_o
);
  import cdot_pkg::*;

  // lane products toward the tree
  cplx_stream_if #(.LANES(LANES)) stream ();

  // valid bits of the two multiplier stages
  // all lanes move in lockstep, so one pair serves every lane
  logic [1:0] mul_v_q;
  logic       tree_busy;

  // tree decides when the pipeline moves
  assign in_ready_o = stream.ready;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      mul_v_q <= '0;
    end else if (stream.ready) begin
      // accepted beat enters stage 1
      mul_v_q[0] <= in_valid_i;
      mul_v_q[1] <= mul_v_q[0];
    end
  end

  assign stream.valid = mul_v_q[1];

  // one multiplier per lane
  for (genvar g = 0; g < LANES; g++) begin : g_lane
    complex_mul u_mul (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .en_i     (stream.ready),
      .a_i      (a_i[g]),
      .b_i      (b_i[g]),
      .conj_i   (conj_i),
      .prod_re_o(stream.prod_re[g]),
      .prod_im_o(stream.prod_im[g])
    );
  end

  // log2(LANES) adder levels
  complex_add_tree #(.LANES(LANES)) u_tree (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .flush_i    (flush_i),
    .out_ready_i(out_ready_i),
    .in         (stream.consumer),
    .result_o   (result_o),
    .out_valid_o(out_valid_o),
    .busy_o     (tree_busy)
  );

  assign busy_o = |mul_v_q || tree_busy;

endmodule

// File: logic/cdot_top.sv
module cdot_top #(
  parameter int LANES = 8
) (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  // operand words, re in the upper half
  input  logic [LANES-1:0][2*cdot_pkg::CPLX_W-1:0]    a_i,
  input  logic [LANES-1:0][2*cdot_pkg::CPLX_W-1:0]    b_i,
  // conjugate every b of this beat
  input  logic                                        conj_i,
  input  logic                                        in_valid_i,
  output logic                                        in_ready_o,
  input  logic                                        flush_i,
  output logic signed [cdot_pkg::ACC_W-1:0]           result_re_o,
  output logic signed [cdot_pkg::ACC_W-1:0]           result_im_o,
  output logic                                        out_valid_o,
  input  logic                                        out_ready_i,
  output logic                                        busy_o
);
  import cdot_pkg::*;

  // operands seen through the union
  cplx_word_u [LANES-1:0] a_word;
  cplx_word_u [LANES-1:0] b_word;

  acc_t result;

  // raw port bits into the union view
  for (genvar g = 0; g < LANES; g++) begin : g_word
    assign a_word[g].raw = a_i[g];
    assign b_word[g].raw = b_i[g];
  end

  complex_dot_product #(.LANES(LANES)) u_dot (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .a_i        (a_word),
    .b_i        (b_word),
    .conj_i     (conj_i),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .flush_i    (flush_i),
    .result_o   (result),
    .out_valid_o(out_valid_o),
    .out_ready_i(out_ready_i),
    .busy_o     (busy_o)
  );

  // split the result into plain ports
  assign result_re_o = result.re;
  assign result_im_o = result.im;

endmodule

// File: tests/tb_clock_gen.sv
module tb_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // free running clock, first rising edge at half a period
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

  // reset held over the first edges, released between edges
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// File: tests/cdot_checker.sv
module cdot_checker (
  input logic                              clk_i,
  input logic                              rst_n_i,
  input logic                              in_ready_i,
  input logic                              out_ready_i,
  input logic                              out_valid_i,
  input logic                              busy_i,
  input logic signed [cdot_pkg::ACC_W-1:0] result_re_i,
  input logic signed [cdot_pkg::ACC_W-1:0] result_im_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // failed assertions, read by the testbench at the end
  int unsigned fail_cnt = 0;

  // synchronous reset clears the output side one edge later
  a_reset_clear: assert property (@(posedge clk_i)
    !rst_n_i |=> (!out_valid_i && !busy_i))
    else begin
      fail_cnt++;
      $error("out_valid_o or busy_o high during reset");
    end

  // held result must not move
  a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_valid_i && !out_ready_i) |=> ($stable(result_re_i) && $stable(result_im_i)))
    else begin
      fail_cnt++;
      $error("result changed while held");
    end

  // a valid result sits in the last stage
  a_valid_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_i |-> busy_i)
    else begin
      fail_cnt++;
      $error("out_valid_o without busy_o");
    end

  // input side stalls exactly when the output is held
  a_ready_rule: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    in_ready_i == !(out_valid_i && !out_ready_i))
    else begin
      fail_cnt++;
      $error("in_ready_o does not follow the output stall");
    end

endmodule

// File: tests/cdot_tb.sv
module cdot_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import cdot_pkg::*;

  localparam int LANES        = 8;
  localparam int LOG_LANES    = $clog2(LANES);
  localparam int LATENCY      = 2 + LOG_LANES;
  localparam int CLK_PERIOD   = 8;
  localparam int STREAM_BEATS = 20;
  localparam int BP_BEATS     = 30;
  localparam int MAX_BEATS    = 32;
  // single, conj pair, stream, backpressure, flush
  localparam int TOTAL_BEATS  = 1 + 2 + STREAM_BEATS + BP_BEATS + 4;
  localparam int WDOG_CYCLES  = TOTAL_BEATS * (LATENCY + 20) + 200;

  logic                            clk;
  logic                            rst_n;
  logic [LANES-1:0][2*CPLX_W-1:0]  a_i;
  logic [LANES-1:0][2*CPLX_W-1:0]  b_i;
  logic                            conj_i;
  logic                            in_valid_i;
  logic                            in_ready_o;
  logic                            flush_i;
  logic signed [ACC_W-1:0]         result_re_o;
  logic signed [ACC_W-1:0]         result_im_o;
  logic                            out_valid_o;
  logic                            out_ready_i;
  logic                            busy_o;

  logic [31:0]  lfsr_q;
  int unsigned  err_value = 0;
  int unsigned  err_other = 0;
  int unsigned  cycle_cnt = 0;
  // expected results in acceptance order
  acc_t         exp_q[$];
  // results seen and the cycle of each
  acc_t         got_log[$];
  int unsigned  got_cyc[$];
  // pregenerated random beats
  cplx_word_u [LANES-1:0] stim_a [MAX_BEATS];
  cplx_word_u [LANES-1:0] stim_b [MAX_BEATS];
  logic                   stim_conj [MAX_BEATS];

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(2)) u_clk_gen (
    .clk_o  (clk),
    .rst_n_o(rst_n)
  );

  cdot_top #(.LANES(LANES)) DUT (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .a_i        (a_i),
    .b_i        (b_i),
    .conj_i     (conj_i),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .flush_i    (flush_i),
    .result_re_o(result_re_o),
    .result_im_o(result_im_o),
    .out_valid_o(out_valid_o),
    .out_ready_i(out_ready_i),
    .busy_o     (busy_o)
  );

  bind cdot_top cdot_checker u_checker (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .in_ready_i (in_ready_o),
    .out_ready_i(out_ready_i),
    .out_valid_i(out_valid_o),
    .busy_i     (busy_o),
    .result_re_i(result_re_o),
    .result_im_i(result_im_o)
  );

  // 32-bit fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one step per bit with the newest bit at the bottom
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // component with a bias toward the two extremes
  function automatic logic [CPLX_W-1:0] rand_comp();
    logic [31:0] sel;
    logic [31:0] bits;
    sel = take_bits(3);
    case (sel[2:0])
      3'd0: return 16'h8000;
      3'd1: return 16'h7fff;
      default: begin
        bits = take_bits(CPLX_W);
        return bits[CPLX_W-1:0];
      end
    endcase
  endfunction

  function automatic cplx_word_u make_word(input int re, input int im);
    cplx_word_u w;
    w.cplx.re = re[CPLX_W-1:0];
    w.cplx.im = im[CPLX_W-1:0];
    return w;
  endfunction

  // sum over lanes of a*b or a*conj(b)
  function automatic acc_t dot_model(input cplx_word_u [LANES-1:0] a,
                                     input cplx_word_u [LANES-1:0] b,
                                     input logic conj);
    longint ar;
    longint ai;
    longint br;
    longint bi;
    longint sre;
    longint sim;
    acc_t   r;
    sre = 0;
    sim = 0;
    for (int g = 0; g < LANES; g++) begin
      ar = $signed(a[g].cplx.re);
      ai = $signed(a[g].cplx.im);
      br = $signed(b[g].cplx.re);
      bi = $signed(b[g].cplx.im);
      if (conj) begin
        bi = -bi;
      end
      sre += ar * br - ai * bi;
      sim += ar * bi + ai * br;
    end
    r.re = ACC_W'(sre);
    r.im = ACC_W'(sim);
    return r;
  endfunction

  task automatic check_result(input acc_t got, input acc_t exp, input string name);
    if (got !== exp) begin
      err_value++;
      $display("error at %0d ns: %s got re=%0d im=%0d, expected re=%0d im=%0d",
               $time, name, got.re, got.im, exp.re, exp.im);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      err_value++;
      $display("error at %0d ns: %s got %b, expected %b", $time, name, got, exp);
    end
  endtask

  // output monitor sees the values from before the edge
  always @(posedge clk) begin
    if (rst_n) begin
      cycle_cnt++;
      check_bit(in_ready_o, !(out_valid_o && !out_ready_i), "in_ready_o");
      if (out_valid_o && out_ready_i) begin
        got_log.push_back({result_re_o, result_im_o});
        got_cyc.push_back(cycle_cnt);
        if (exp_q.size() == 0) begin
          err_other++;
          $display("unexpected result at %0d ns, no accepted beat was waiting", $time);
        end else begin
          check_result({result_re_o, result_im_o}, exp_q.pop_front(), "result");
        end
      end
    end
  end

  // drive on the falling edge and hold until accepted
  task automatic send_beat(input cplx_word_u [LANES-1:0] a,
                           input cplx_word_u [LANES-1:0] b,
                           input logic conj);
    @(negedge clk);
    a_i        = a;
    b_i        = b;
    conj_i     = conj;
    in_valid_i = 1'b1;
    @(posedge clk);
    while (!in_ready_o) begin
      @(posedge clk);
    end
    exp_q.push_back(dot_model(a, b, conj));
  endtask

  task automatic idle_input();
    @(negedge clk);
    in_valid_i = 1'b0;
  endtask

  task automatic wait_drain(input int max_cycles);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      err_other++;
      $display("%0d results still missing after waiting %0d cycles", exp_q.size(), n);
      exp_q.delete();
    end
  endtask

  task automatic gen_beats(input int n);
    logic [31:0] bits;
    for (int i = 0; i < n; i++) begin
      for (int g = 0; g < LANES; g++) begin
        stim_a[i][g].cplx.re = rand_comp();
        stim_a[i][g].cplx.im = rand_comp();
        stim_b[i][g].cplx.re = rand_comp();
        stim_b[i][g].cplx.im = rand_comp();
      end
      bits = take_bits(1);
      stim_conj[i] = bits[0];
    end
  endtask

  task automatic test_single();
    cplx_word_u [LANES-1:0] a;
    cplx_word_u [LANES-1:0] b;
    for (int g = 0; g < LANES; g++) begin
      a[g] = make_word(g + 1, -g);
      b[g] = make_word(2, g + 3);
    end
    send_beat(a, b, 1'b0);
    // k counts edges with the accepting one as edge 1
    for (int k = 1; k <= LATENCY; k++) begin
      @(negedge clk);
      if (k == 1) begin
        in_valid_i = 1'b0;
      end
      check_bit(busy_o, 1'b1, "busy_o");
      check_bit(out_valid_o, k == LATENCY, "out_valid_o");
    end
    wait_drain(4 * LATENCY);
  endtask

  task automatic test_conj();
    cplx_word_u [LANES-1:0] a;
    cplx_word_u [LANES-1:0] b;
    longint cross_ii;
    longint cross_ri;
    acc_t   plain;
    acc_t   derived;
    int     base;
    cross_ii = 0;
    cross_ri = 0;
    for (int g = 0; g < LANES; g++) begin
      a[g] = make_word(100 * g + 7, -(50 * g + 3));
      b[g] = make_word(-(30 * g + 11), 20 * g + 5);
      cross_ii += longint'(-(50 * g + 3)) * (20 * g + 5);
      cross_ri += longint'(100 * g + 7) * (20 * g + 5);
    end
    plain = dot_model(a, b, 1'b0);
    base = got_log.size();
    send_beat(a, b, 1'b0);
    send_beat(a, b, 1'b1);
    idle_input();
    wait_drain(4 * LATENCY);
    if (got_log.size() != base + 2) begin
      err_other++;
      $display("conjugate test saw %0d results instead of 2", got_log.size() - base);
    end else begin
      // negating every bi flips the ai*bi and ar*bi terms
      derived.re = ACC_W'(plain.re + 2 * cross_ii);
      derived.im = ACC_W'(plain.im - 2 * cross_ri);
      check_result(got_log[base+1], derived, "conjugated result");
    end
  endtask

  task automatic test_stream();
    int base;
    gen_beats(STREAM_BEATS);
    // corner beats up front
    // -32768 gets negated under conj
    for (int g = 0; g < LANES; g++) begin
      stim_a[0][g] = make_word(-32768, -32768);
      stim_b[0][g] = make_word(-32768, -32768);
      stim_a[1][g] = make_word(32767, -32768);
      stim_b[1][g] = make_word(-32768, 32767);
      stim_a[2][g] = make_word(-32767, 32767);
      stim_b[2][g] = make_word(32767, -32767);
    end
    stim_conj[0] = 1'b1;
    stim_conj[1] = 1'b0;
    stim_conj[2] = 1'b1;
    base = got_log.size();
    for (int i = 0; i < STREAM_BEATS; i++) begin
      send_beat(stim_a[i], stim_b[i], stim_conj[i]);
    end
    idle_input();
    wait_drain(STREAM_BEATS + 4 * LATENCY);
    if (got_log.size() != base + STREAM_BEATS) begin
      err_other++;
      $display("stream test saw %0d results instead of %0d", got_log.size() - base,
               STREAM_BEATS);
    end
    for (int i = base + 1; i < got_cyc.size(); i++) begin
      if (got_cyc[i] != got_cyc[i-1] + 1) begin
        err_other++;
        $display("stream result %0d did not follow its predecessor directly", i - base);
      end
    end
  endtask

  task automatic test_backpressure();
    logic [31:0] bits;
    logic        done;
    int          base;
    gen_beats(BP_BEATS);
    base = got_log.size();
    done = 1'b0;
    fork
      begin
        for (int i = 0; i < BP_BEATS; i++) begin
          send_beat(stim_a[i], stim_b[i], stim_conj[i]);
        end
        idle_input();
        wait_drain(BP_BEATS * (LATENCY + 20));
        done = 1'b1;
      end
      begin
        // random output stalls
        while (!done) begin
          @(negedge clk);
          bits = take_bits(1);
          out_ready_i = bits[0];
        end
      end
    join
    @(negedge clk);
    out_ready_i = 1'b1;
    if (got_log.size() != base + BP_BEATS) begin
      err_other++;
      $display("backpressure test saw %0d results instead of %0d", got_log.size() - base,
               BP_BEATS);
    end
  endtask

  task automatic test_flush();
    cplx_word_u [LANES-1:0] a;
    cplx_word_u [LANES-1:0] b;
    int base;
    for (int g = 0; g < LANES; g++) begin
      a[g] = make_word(1000 + g, g - 500);
      b[g] = make_word(-3 * g, 77);
    end
    @(negedge clk);
    out_ready_i = 1'b0;
    base = got_log.size();
    for (int i = 0; i < 3; i++) begin
      send_beat(a, b, i[0]);
    end
    @(negedge clk);
    in_valid_i = 1'b0;
    flush_i    = 1'b1;
    @(negedge clk);
    flush_i = 1'b0;
    // the three beats are gone
    exp_q.delete();
    for (int k = 0; k < 2 * LATENCY; k++) begin
      check_bit(busy_o, 1'b0, "busy_o");
      check_bit(out_valid_o, 1'b0, "out_valid_o");
      @(negedge clk);
    end
    out_ready_i = 1'b1;
    send_beat(a, b, 1'b1);
    idle_input();
    wait_drain(4 * LATENCY);
    if (got_log.size() != base + 1) begin
      err_other++;
      $display("flush test saw %0d results instead of 1", got_log.size() - base);
    end
  endtask

  task automatic finish_run();
    int unsigned total;
    total = err_value + err_other + DUT.u_checker.fail_cnt;
    $display("value errors %0d, other errors %0d, assertion failures %0d, results %0d",
             err_value, err_other, DUT.u_checker.fail_cnt, got_log.size());
    if (total == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  // budget scales with the beats sent over all tests
  initial begin
    #(WDOG_CYCLES * CLK_PERIOD);
    err_other++;
    $display("watchdog expired after %0d cycles, the tests did not finish", WDOG_CYCLES);
    finish_run();
  end

  initial begin
    a_i         = '0;
    b_i         = '0;
    conj_i      = 1'b0;
    in_valid_i  = 1'b0;
    flush_i     = 1'b0;
    out_ready_i = 1'b1;
    lfsr_q      = 32'hceab;
    @(posedge rst_n);
    test_single();
    test_conj();
    test_stream();
    test_backpressure();
    test_flush();
    finish_run();
  end

endmodule

// File: cdot.f
logic/cdot_pkg.sv
logic/cplx_stream_if.sv
logic/complex_mul.sv
logic/complex_add_tree.sv
logic/complex_dot_product.sv
logic/cdot_top.sv
tests/tb_clock_gen.sv
tests/cdot_checker.sv
tests/cdot_tb.sv
